/* Bender.yml */
package:
  name: port_selector

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/sel_types_pkg.sv
      - src/sel_pipe_pkg.sv
      - src/sel_capture.sv
      - src/max_finder_tree.sv
      - src/sel_grant.sv
      - src/port_selector_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/port_selector_sva.sv
      - verification/port_selector_tb.sv

/* files.f */
+incdir+src
src/sel_types_pkg.sv
src/sel_pipe_pkg.sv
src/sel_capture.sv
src/max_finder_tree.sv
src/sel_grant.sv
src/port_selector_top.sv
verification/port_selector_sva.sv
verification/port_selector_tb.sv

/* src/max_finder_tree.sv */
`timescale 1ns/10ps

`include "sel_cfg.svh"

module max_finder_tree
  import sel_types_pkg::*;
  import sel_pipe_pkg::*;
#(
  parameter int PORT_COUNT = `SEL_PORT_COUNT,
  parameter int DATA_WIDTH = `SEL_PRIO_WIDTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  sel_req_s req,
  output sel_win_s win
);

  localparam int CEIL_PORT_CNT = 2 ** $clog2(PORT_COUNT);

  logic [PORT_COUNT*DATA_WIDTH-1:0]    masked_values;
  logic [CEIL_PORT_CNT*DATA_WIDTH-1:0] padded_values;
  prio_t                               tree_max;
  port_idx_t                           tree_ptr;
  logic                                any_found;

  logic      live_q;
  logic      found_q;
  prio_t     prio_q;
  port_idx_t idx_q;

  // Invalid ports compete with priority 0
  always_comb begin
    for (int i = 0; i < PORT_COUNT; i++) begin
      if (req.valids[i]) begin
        masked_values[i*DATA_WIDTH +: DATA_WIDTH] = req.prios[i*DATA_WIDTH +: DATA_WIDTH];
      end else begin
        masked_values[i*DATA_WIDTH +: DATA_WIDTH] = '0;
      end
    end
  end

  // Zero padding up to the next power of two
  always_comb begin
    padded_values = '0;
    padded_values[PORT_COUNT*DATA_WIDTH-1:0] = masked_values;
  end

  max_finder_tree_pow_of_2 #(
    .PORT_COUNT(CEIL_PORT_CNT),
    .DATA_WIDTH(DATA_WIDTH)
  ) max_finder (
    .values (padded_values),
    .max_val(tree_max),
    .max_ptr(tree_ptr)
  );

  // Priority 0 counts as absent
  assign any_found = |masked_values;

  // ********************
  // Result register
  // ********************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live_q  <= 1'b0;
      found_q <= 1'b0;
    end else begin
      live_q  <= req.live;
      found_q <= any_found;
    end
  end

  always_ff @(posedge clk) begin
    prio_q <= tree_max;
    idx_q  <= tree_ptr;
  end

  assign win.prio  = prio_q;
  assign win.idx   = idx_q;
  assign win.found = found_q;
  assign win.live  = live_q;

endmodule

module max_finder_tree_pow_of_2
  import sel_types_pkg::*;
#(
  parameter int PORT_COUNT = 16,
  parameter int DATA_WIDTH = 8
) (
  input  logic [PORT_COUNT*DATA_WIDTH-1:0] values,
  output prio_t                            max_val,
  output port_idx_t                        max_ptr
);

  localparam int LEVELS     = $clog2(PORT_COUNT);
  localparam int ADDR_WIDTH = LEVELS;

  // Node j of level l covers inputs j*2^l up to (j+1)*2^l - 1
  logic [DATA_WIDTH-1:0] lvl_val [0:LEVELS][0:PORT_COUNT-1];
  logic [ADDR_WIDTH-1:0] lvl_ptr [0:LEVELS][0:PORT_COUNT-1];

  genvar l, j;

  generate
    for (j = 0; j < PORT_COUNT; j++) begin : g_leaf
      assign lvl_val[0][j] = values[j*DATA_WIDTH +: DATA_WIDTH];
      assign lvl_ptr[0][j] = '0;
    end

    for (l = 1; l <= LEVELS; l++) begin : g_level
      for (j = 0; j < (PORT_COUNT >> l); j++) begin : g_node
        logic upper_wins;

        // Strict compare, so a tie keeps the lower index
        assign upper_wins = lvl_val[l-1][2*j+1] > lvl_val[l-1][2*j];

        assign lvl_val[l][j] = upper_wins ? lvl_val[l-1][2*j+1] : lvl_val[l-1][2*j];

        // This level settles index bit l-1
        assign lvl_ptr[l][j] = (upper_wins ? lvl_ptr[l-1][2*j+1] : lvl_ptr[l-1][2*j]) |
                               (ADDR_WIDTH'(upper_wins) << (l - 1));
      end
    end
  endgenerate

  assign max_val = lvl_val[LEVELS][0];
  assign max_ptr = lvl_ptr[LEVELS][0];

endmodule

/* src/port_selector_top.sv */
`timescale 1ns/10ps

`include "sel_cfg.svh"

module port_selector_top
  import sel_types_pkg::*;
  import sel_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_strobe,
  input  prio_vec_t req_prios,
  input  port_vec_t req_valids,
  input  logic      mask_load,
  input  port_vec_t mask_data,
  output logic      win_strobe,
  output logic      win_found,
  output port_idx_t win_idx,
  output prio_t     win_prio,
  output port_vec_t grant
);

  sel_req_s cap_req;
  sel_win_s tree_win;

  sel_capture capture0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_strobe(req_strobe),
    .req_prios (req_prios),
    .req_valids(req_valids),
    .mask_load (mask_load),
    .mask_data (mask_data),
    .req       (cap_req)
  );

  max_finder_tree #(
    .PORT_COUNT(`SEL_PORT_COUNT),
    .DATA_WIDTH(`SEL_PRIO_WIDTH)
  ) tree0 (
    .clk  (clk),
    .rst_n(rst_n),
    .req  (cap_req),
    .win  (tree_win)
  );

  sel_grant grant0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .win       (tree_win),
    .win_strobe(win_strobe),
    .win_found (win_found),
    .win_idx   (win_idx),
    .win_prio  (win_prio),
    .grant     (grant)
  );

endmodule

/* src/sel_capture.sv */
`timescale 1ns/10ps

module sel_capture
  import sel_types_pkg::*;
  import sel_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_strobe,
  input  prio_vec_t req_prios,
  input  port_vec_t req_valids,
  input  logic      mask_load,
  input  port_vec_t mask_data,
  output sel_req_s  req
);

  port_vec_t mask_q;
  logic      live_q;
  prio_vec_t prios_q;
  port_vec_t valids_q;

  // ********************
  // Port enable mask
  // ********************

  // All ports enabled out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mask_q <= '1;
    end else if (mask_load) begin
      mask_q <= mask_data;
    end
  end

  // ********************
  // Request register
  // ********************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= req_strobe;
    end
  end

  // A load on the same edge only takes effect for later requests
  always_ff @(posedge clk) begin
    prios_q  <= req_prios;
    valids_q <= req_valids & mask_q;
  end

  assign req.prios  = prios_q;
  assign req.valids = valids_q;
  assign req.live   = live_q;

endmodule

/* src/sel_cfg.svh */
`ifndef SEL_CFG_SVH
`define SEL_CFG_SVH

// ********************
// Port selector sizing
// ********************

// Ports offered to the scheduler
`define SEL_PORT_COUNT 12

// Bits per port priority
`define SEL_PRIO_WIDTH 8

`define SEL_IDX_WIDTH $clog2(`SEL_PORT_COUNT)

`endif

/* src/sel_grant.sv */
`timescale 1ns/10ps

module sel_grant
  import sel_types_pkg::*;
  import sel_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  sel_win_s  win,
  output logic      win_strobe,
  output logic      win_found,
  output port_idx_t win_idx,
  output prio_t     win_prio,
  output port_vec_t grant
);

  logic hit;

  // Only a live slot can report a winner
  assign hit = win.found & win.live;

  // ********************
  // Winner register
  // ********************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_strobe <= 1'b0;
      win_found  <= 1'b0;
      win_idx    <= '0;
      win_prio   <= '0;
    end else begin
      win_strobe <= win.live;
      win_found  <= hit;
      if (hit) begin
        win_idx  <= win.idx;
        win_prio <= win.prio;
      end else begin
        win_idx  <= '0;
        win_prio <= '0;
      end
    end
  end

  // One-hot decode of the registered index
  always_comb begin
    grant = '0;
    if (win_found) begin
      grant = port_vec_t'(1) << win_idx;
    end
  end

endmodule

/* src/sel_pipe_pkg.sv */
package sel_pipe_pkg;

  import sel_types_pkg::*;

  // ********************
  // Stage payloads
  // ********************

  // Capture to tree
  typedef struct packed {
    prio_vec_t prios;
    port_vec_t valids;
    logic      live;
  } sel_req_s;

  // Tree to grant
  typedef struct packed {
    prio_t     prio;
    port_idx_t idx;
    logic      found;
    logic      live;
  } sel_win_s;

endpackage

/* src/sel_types_pkg.sv */
`include "sel_cfg.svh"

package sel_types_pkg;

  // One port priority
  typedef logic [`SEL_PRIO_WIDTH-1:0] prio_t;

  // Port number, 0 to port count minus 1
  typedef logic [`SEL_IDX_WIDTH-1:0] port_idx_t;

  // One bit per port, used for valids, mask and grant
  typedef logic [`SEL_PORT_COUNT-1:0] port_vec_t;

  // All priorities, port 0 in the low bits
  typedef logic [`SEL_PORT_COUNT*`SEL_PRIO_WIDTH-1:0] prio_vec_t;

endpackage

/* verification/port_selector_sva.sv */
`timescale 1ns/10ps

module port_selector_sva
  import sel_types_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      win_strobe,
  input logic      win_found,
  input port_idx_t win_idx,
  input port_vec_t grant
);

  int unsigned fail_count = 0;

  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant))
    else begin
      fail_count++;
      $error("grant has more than one bit set");
    end

  // A grant only with a found winner on a strobe
  grant_qualified: assert property (@(posedge clk) disable iff (!rst_n)
    (grant != '0) |-> (win_strobe && win_found))
    else begin
      fail_count++;
      $error("grant set without win_strobe and win_found");
    end

  grant_at_idx: assert property (@(posedge clk) disable iff (!rst_n) win_found |-> grant[win_idx])
    else begin
      fail_count++;
      $error("grant bit at win_idx is clear");
    end

  strobe_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !win_strobe)
    else begin
      fail_count++;
      $error("win_strobe high right after reset");
    end

endmodule

bind port_selector_top port_selector_sva sva0 (.*);

/* verification/port_selector_tb.sv */
`timescale 1ns/10ps

`include "sel_cfg.svh"

module port_selector_tb
  import sel_types_pkg::*;
();

  localparam string TESTS_FILE = "verification/port_selector_tests.txt";

  // One expected winner and the cycle it is due
  typedef struct packed {
    logic        found;
    port_idx_t   idx;
    prio_t       prio;
    logic [31:0] due;
  } expect_s;

  logic      clk;
  logic      rst_n;
  logic      req_strobe;
  prio_vec_t req_prios;
  port_vec_t req_valids;
  logic      mask_load;
  port_vec_t mask_data;
  logic      win_strobe;
  logic      win_found;
  port_idx_t win_idx;
  prio_t     win_prio;
  port_vec_t grant;

  string   lines[$];
  expect_s pending[$];
  int      cycle = 0;
  int      cycle_limit = 0;

  port_selector_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_strobe(req_strobe),
    .req_prios (req_prios),
    .req_valids(req_valids),
    .mask_load (mask_load),
    .mask_data (mask_data),
    .win_strobe(win_strobe),
    .win_found (win_found),
    .win_idx   (win_idx),
    .win_prio  (win_prio),
    .grant     (grant)
  );

  always #10 clk = ~clk;

  // ********************
  // Compares
  // ********************

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_prio(input string name, input prio_t got, input prio_t want);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
    end
  endtask

  task automatic check_idx(input string name, input port_idx_t got, input port_idx_t want);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: %s got %0d expected %0d", $time, name, got, want));
    end
  endtask

  task automatic check_grant(input string name, input port_vec_t got, input port_vec_t want);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, want));
    end
  endtask

  // ********************
  // Stimulus
  // ********************

  task automatic load_tests();
    int    fd;
    string line;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      abort_run({"cannot open the tests file ", TESTS_FILE});
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // Strobe low and random data that must be ignored
  task automatic apply_idle();
    req_strobe = 1'b0;
    mask_load  = 1'b0;
    req_prios  = {$urandom, $urandom, $urandom};
    req_valids = port_vec_t'($urandom);
    mask_data  = port_vec_t'($urandom);
  endtask

  task automatic run_line(input string line);
    prio_t     pr [`SEL_PORT_COUNT];
    port_vec_t valids;
    int        found;
    int        idx;
    prio_t     prio;
    int        n;
    expect_s   item;
    if (line[0] == "M") begin
      n = $sscanf(line, "M %h", valids);
      if (n != 1) begin
        abort_run({"malformed mask line in the tests file: ", line});
      end else begin
        req_strobe = 1'b0;
        mask_load  = 1'b1;
        mask_data  = valids;
      end
    end else begin
      n = $sscanf(line, "R %h %h %h %h %h %h %h %h %h %h %h %h %h %d %d %h",
                  pr[0], pr[1], pr[2], pr[3], pr[4], pr[5], pr[6], pr[7],
                  pr[8], pr[9], pr[10], pr[11], valids, found, idx, prio);
      if (n != 16) begin
        abort_run({"malformed request line in the tests file: ", line});
      end else begin
        for (int i = 0; i < `SEL_PORT_COUNT; i++) begin
          req_prios[i*`SEL_PRIO_WIDTH +: `SEL_PRIO_WIDTH] = pr[i];
        end
        req_valids = valids;
        req_strobe = 1'b1;
        mask_load  = 1'b0;
        item.found = found[0];
        item.idx   = port_idx_t'(idx);
        item.prio  = prio;
        // Sampled at the next edge and visible two edges later
        item.due   = cycle + 3;
        pending.push_back(item);
      end
    end
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle_limit > 0 && cycle >= cycle_limit) begin
      abort_run($sformatf("timeout: the test did not finish within %0d cycles", cycle_limit));
    end
  end

  always @(negedge clk) begin
    expect_s   item;
    port_vec_t want_grant;
    if (rst_n && dut0.sva0.fail_count != 0) begin
      abort_run("an assertion on the grant outputs failed");
    end else if (rst_n && win_strobe) begin
      if (pending.size() == 0) begin
        abort_run("win_strobe was high with no request outstanding");
      end else begin
        item = pending.pop_front();
        if (cycle != item.due) begin
          abort_run($sformatf("mismatch at %0t: win_strobe cycle got %0d expected %0d",
                              $time, cycle, item.due));
        end else begin
          // Only the winning port's bit is set
          want_grant = '0;
          if (item.found) begin
            want_grant[item.idx] = 1'b1;
          end
          check_bit("win_found", win_found, item.found);
          check_idx("win_idx", win_idx, item.idx);
          check_prio("win_prio", win_prio, item.prio);
          check_grant("grant", grant, want_grant);
        end
      end
    end
  end

  initial begin
    int idle;
    void'($urandom(29608));
    clk        = 1'b0;
    rst_n      = 1'b0;
    req_strobe = 1'b0;
    req_prios  = '0;
    req_valids = '0;
    mask_load  = 1'b0;
    mask_data  = '1;
    load_tests();
    cycle_limit = (lines.size() + 10) * 4;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    foreach (lines[k]) begin
      @(negedge clk);
      run_line(lines[k]);
      // Requests run back to back and gaps only follow mask loads
      if (lines[k][0] == "M") begin
        idle = $urandom % 3;
        repeat (idle) begin
          @(negedge clk);
          apply_idle();
        end
      end
    end
    @(negedge clk);
    apply_idle();
    while (pending.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (dut0.sva0.fail_count == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("an assertion on the grant outputs failed");
    end
  end

endmodule

/* verification/port_selector_tests.txt */
# M mask | R prio0..prio11 valids found idx prio (hex except found and idx)
# mask and valids are 12-bit hex with port 0 in bit 0
R 00 00 00 40 00 00 00 00 00 00 00 00 008 1 3 40
R 01 00 00 00 00 00 00 00 00 00 00 00 001 1 0 01
R 00 00 00 00 00 00 00 00 00 00 00 ff 800 1 11 ff
R ff 00 00 00 00 00 00 7f 00 00 00 ee 080 1 7 7f
R 10 20 30 25 00 11 12 13 14 15 16 05 fff 1 2 30
R 01 02 03 04 50 06 07 08 09 50 0a 0b fff 1 4 50
R 33 33 33 33 33 33 33 33 33 33 33 33 fff 1 0 33
R 00 01 02 03 04 05 06 07 08 09 9c 9c fff 1 10 9c
R 11 22 33 44 55 66 77 88 99 aa bb c8 fff 1 11 c8
R 00 20 00 00 00 f0 80 00 00 00 00 00 042 1 6 80
R 00 00 00 00 00 00 00 00 00 00 00 00 fff 0 0 00
R 5a a5 ff 80 7f 01 02 03 04 05 06 07 000 0 0 00
R 00 ff ff ff ff ff ff ff ff ff ff ff 001 0 0 00
M 7ff
R 11 22 33 44 55 66 77 88 99 aa bb c8 fff 1 10 bb
R 00 00 00 00 00 00 00 00 00 00 00 c8 800 0 0 00
M 7f0
R ff fe fd fc 10 20 30 90 50 60 70 ff fff 1 7 90
R ff fe fd fc 00 00 00 00 00 00 00 ff 80f 0 0 00
M fff
R ff fe fd fc 00 00 00 00 00 00 00 ff 80f 1 0 ff
R 11 22 33 44 55 66 77 88 99 aa bb c8 fff 1 11 c8
R 00 00 00 00 00 00 00 00 01 00 00 00 100 1 8 01
R 00 00 00 00 00 00 00 00 00 00 00 00 000 0 0 00
R 00 00 aa 00 00 00 00 00 00 ab 00 00 204 1 9 ab
R 00 00 00 7f 7f 7e 00 00 00 00 00 00 038 1 3 7f
M 000
R 11 22 33 44 55 66 77 88 99 aa bb c8 fff 0 0 00
M fff
R 00 00 00 00 00 00 42 00 00 00 00 00 fff 1 6 42
